//--- fpMul32_macros.svh
// constants shared by the fp32 multiplier stages and its testbench
`ifndef FPMUL32_MACROS_SVH
`define FPMUL32_MACROS_SVH

// ------------------------------
// exponent field
// ------------------------------
`define FP_EXP_W	8	// biased exponent width
`define FP_BIAS		127	// exponent bias
`define FP_EMAX		255	// all ones exponent, infinity and nan

// ------------------------------
// pipeline
// ------------------------------
// decode, execute and round stages
// one register each
`define FP_LATENCY	3

`endif

//--- fp32Pkg.sv
// types passed between the decode execute and round stages of the fp32 multiplier
`default_nettype none
`include "fpMul32_macros.svh"

package fp32Pkg;

	// ------------------------------
	// ieee 754 single word
	// ------------------------------
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;	// biased
		logic [22:0] sig;	// fraction only, hidden bit implied
	} FP32;

	// wide intermediate form fed to the rounder
	// sig = hidden, 23 fraction bits, guard, round, sticky
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;	// 0 marks a denormal
		logic [26:0] sig;
	} FP32N;

	// class of the product, decided once in decode
	typedef enum logic [1:0] {
		fcNorm,	// finite nonzero, value comes from the datapath
		fcZero,	// signed zero
		fcInf,	// signed infinity
		fcNan	// quiet nan
	} fpClass;

	// ------------------------------
	// rounding modes, 5..7 illegal
	// ------------------------------
	typedef enum logic [2:0] {
		rmNearEven = 3'd0,	// nearest, ties to even
		rmZero     = 3'd1,	// truncate
		rmPlusInf  = 3'd2,	// toward +inf
		rmMinusInf = 3'd3,	// toward -inf
		rmNearMax  = 3'd4	// nearest, ties away from zero
	} roundMode;

	// decode stage record
	typedef struct packed {
		logic signA;
		logic signB;
		logic [`FP_EXP_W-1:0] expA;
		logic [`FP_EXP_W-1:0] expB;
		logic [23:0] sigA;	// hidden bit restored, zero when flushed
		logic [23:0] sigB;
		fpClass cls;	// product class
		roundMode rm;	// travels with the operands
	} decodedOp;

	// execute stage record
	typedef struct packed {
		FP32N num;	// normalized or denormalized product
		fpClass cls;
		roundMode rm;
	} execResult;

endpackage

`default_nettype wire

//--- fpMul32Decode.sv
// first multiplier stage unpacks both operands and classifies the product
`default_nettype none
`include "fpMul32_macros.svh"

module fpMul32Decode (
	input wire logic clk,
	input wire logic arstN,
	input wire logic inValid,
	input wire fp32Pkg::roundMode rm,
	input wire fp32Pkg::FP32 a,
	input wire fp32Pkg::FP32 b,
	output logic decValid,
	output fp32Pkg::decodedOp decOp
);
	import fp32Pkg::*;

	// ------------------------------
	// operand tests
	// ------------------------------
	logic aZero, bZero;	// exponent 0, denormals included
	logic aInf, bInf;
	logic aNan, bNan;
	fpClass cls;

	assign aZero = a.exp == '0;	// denormal is flushed here
	assign bZero = b.exp == '0;
	assign aInf = (a.exp == `FP_EXP_W'(`FP_EMAX)) && (a.sig == '0);
	assign bInf = (b.exp == `FP_EXP_W'(`FP_EMAX)) && (b.sig == '0);
	assign aNan = (a.exp == `FP_EXP_W'(`FP_EMAX)) && (a.sig != '0);
	assign bNan = (b.exp == `FP_EXP_W'(`FP_EMAX)) && (b.sig != '0);

	// class priority: nan, inf*0 -> nan, inf, zero
	always_comb begin
		if (aNan || bNan || (aInf && bZero) || (bInf && aZero))
			cls = fcNan;
		else if (aInf || bInf)
			cls = fcInf;
		else if (aZero || bZero)
			cls = fcZero;
		else
			cls = fcNorm;
	end

	// ------------------------------
	// stage register
	// ------------------------------
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			decValid <= 1'b0;
		else
			decValid <= inValid;
	end

	// payload only loads on a valid operation
	always_ff @(posedge clk) begin
		if (inValid) begin
			decOp.signA <= a.sign;
			decOp.signB <= b.sign;
			decOp.expA <= a.exp;
			decOp.expB <= b.exp;
			decOp.sigA <= aZero ? 24'd0 : {1'b1, a.sig};	// restore hidden bit
			decOp.sigB <= bZero ? 24'd0 : {1'b1, b.sig};
			decOp.cls <= cls;
			decOp.rm <= rm;
		end
	end

	// an illegal mode would fall through to truncation in the rounder two cycles later
	rmLegal: assert property (@(posedge clk) disable iff (!arstN)
		inValid |-> !$isunknown(rm) && (rm <= rmNearMax));

endmodule

`default_nettype wire

//--- fpMul32Execute.sv
// second multiplier stage forms the significand product and normalizes it into FP32N
`default_nettype none
`include "fpMul32_macros.svh"

module fpMul32Execute (
	input wire logic clk,
	input wire logic arstN,
	input wire logic decValid,
	input wire fp32Pkg::decodedOp decOp,
	output logic exValid,
	output fp32Pkg::execResult exRes
);
	import fp32Pkg::*;

	// ------------------------------
	// multiply
	// ------------------------------
	logic [47:0] prod;	// 1.x * 1.x lands in [1,4)
	logic signed [9:0] expSum;	// range -125..381
	logic signed [9:0] normExp;
	logic [47:0] normSig;	// hidden bit at 47

	assign prod = 48'(decOp.sigA) * 48'(decOp.sigB);
	assign expSum = 10'(decOp.expA) + 10'(decOp.expB) - 10'(`FP_BIAS);

	// top bit set means the product is >= 2 and takes one more exponent
	always_comb begin
		if (prod[47]) begin
			normSig = prod;
			normExp = expSum + 10'sd1;
		end
		else begin
			normSig = {prod[46:0], 1'b0};
			normExp = expSum;
		end
	end

	// ------------------------------
	// fold into guard/round/sticky
	// ------------------------------
	logic [26:0] grsSig;	// hidden, fraction, g, r, s

	assign grsSig = {normSig[47:22], |normSig[21:0]};

	// ------------------------------
	// denormal shift
	// ------------------------------
	logic signed [9:0] deficit;	// distance below exponent 1
	logic [4:0] shAmt;	// capped at 27 where everything lands in sticky
	logic dnLost;
	logic [26:0] dnSig;

	assign deficit = 10'sd1 - normExp;
	assign shAmt = (deficit > 10'sd27) ? 5'd27 : deficit[4:0];
	// bits pushed out below sticky still count toward it
	assign dnLost = |(grsSig & ~(27'h7FFFFFF << shAmt));
	assign dnSig = (grsSig >> shAmt) | {26'd0, dnLost};

	// ------------------------------
	// range select
	// ------------------------------
	FP32N num;

	always_comb begin
		num.sign = decOp.signA ^ decOp.signB;
		if (normExp >= `FP_EMAX) begin	// overflow saturates to infinity
			num.exp = `FP_EXP_W'(`FP_EMAX);
			num.sig = '0;
		end
		else if (normExp < 1) begin	// below normal range
			num.exp = '0;
			num.sig = dnSig;
		end
		else begin
			num.exp = normExp[`FP_EXP_W-1:0];
			num.sig = grsSig;
		end
	end

	// ------------------------------
	// stage register
	// ------------------------------
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			exValid <= 1'b0;
		else
			exValid <= decValid;
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			exRes.num <= num;
			exRes.cls <= decOp.cls;	// class and mode ride along
			exRes.rm <= decOp.rm;
		end
	end

	// the rounder relies on exp 0 meaning no hidden bit and saturated infinities are left out
	hiddenMatchesExp: assert property (@(posedge clk) disable iff (!arstN)
		exValid && (exRes.cls == fcNorm) && (exRes.num.exp != `FP_EXP_W'(`FP_EMAX))
		|-> exRes.num.sig[26] == (exRes.num.exp != '0));

endmodule

`default_nettype wire

//--- fpRound32.sv
// result stage rounds the FP32N product under the selected mode and packs an fp32 word
`default_nettype none
`include "fpMul32_macros.svh"

module fpRound32 (
	input wire logic clk,
	input wire logic arstN,
	input wire logic exValid,
	input wire fp32Pkg::execResult exRes,
	output logic outValid,
	output fp32Pkg::FP32 result
);
	import fp32Pkg::*;

	localparam logic [31:0] QNan = 32'h7FC00000;	// default quiet nan

	// ------------------------------
	// round increment
	// ------------------------------
	logic lsb, g, r, s;
	logic xInf;	// exponent already all ones
	logic rnd;

	assign lsb = exRes.num.sig[3];	// last kept fraction bit
	assign g = exRes.num.sig[2];
	assign r = exRes.num.sig[1];
	assign s = exRes.num.sig[0];
	assign xInf = exRes.num.exp == `FP_EXP_W'(`FP_EMAX);

	always_comb begin
		case (exRes.rm)
			rmNearEven: rnd = g & (r | s | lsb);	// tie goes to even
			rmZero: rnd = 1'b0;
			rmPlusInf: rnd = (g | r | s) & ~exRes.num.sign;
			rmMinusInf: rnd = (g | r | s) & exRes.num.sign;
			rmNearMax: rnd = g;	// tie goes away from zero
			default: rnd = 1'b0;
		endcase
		if (xInf)
			rnd = 1'b0;	// infinity is never rounded
	end

	// ------------------------------
	// add with carry into exponent
	// ------------------------------
	// a fraction carry bumps the exponent, denormal -> normal or max -> inf
	logic [30:0] rndSum;	// {exp, fraction}
	logic [`FP_EXP_W-1:0] rndExp;
	logic [22:0] rndFrac;

	assign rndSum = {exRes.num.exp, exRes.num.sig[25:3]} + 31'(rnd);
	assign rndExp = rndSum[30:23];
	assign rndFrac = (rndExp == `FP_EXP_W'(`FP_EMAX)) ? 23'd0 : rndSum[22:0];	// clean inf

	// ------------------------------
	// special override
	// ------------------------------
	logic [31:0] packed32;

	always_comb begin
		case (exRes.cls)
			fcNan: packed32 = QNan;
			fcInf: packed32 = {exRes.num.sign, `FP_EXP_W'(`FP_EMAX), 23'd0};
			fcZero: packed32 = {exRes.num.sign, 31'd0};
			default: packed32 = {exRes.num.sign, rndExp, rndFrac};
		endcase
	end

	// ------------------------------
	// output register
	// ------------------------------
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			outValid <= 1'b0;
		else
			outValid <= exValid;
	end

	always_ff @(posedge clk) begin
		if (exValid)
			result <= packed32;
	end

	// an unknown here points back to an unloaded payload somewhere up the pipe
	resultKnown: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> !$isunknown(result));

endmodule

`default_nettype wire

//--- fpMul32.sv
// three stage pipelined fp32 multiplier top with decode execute and round stages
`default_nettype none

module fpMul32 (
	input wire logic clk,
	input wire logic arstN,
	input wire logic inValid,
	input wire fp32Pkg::roundMode rm,
	input wire fp32Pkg::FP32 a,
	input wire fp32Pkg::FP32 b,
	output logic outValid,
	output fp32Pkg::FP32 result
);
	import fp32Pkg::*;

	// ------------------------------
	// stage links
	// ------------------------------
	logic decValid;	// decode -> execute
	decodedOp decOp;
	logic exValid;	// execute -> round
	execResult exRes;

	// stage 1 unpack and classify
	fpMul32Decode uDecode (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.rm(rm),
		.a(a),
		.b(b),
		.decValid(decValid),
		.decOp(decOp)
	);

	// stage 2 multiply and normalize
	fpMul32Execute uExecute (
		.clk(clk),
		.arstN(arstN),
		.decValid(decValid),
		.decOp(decOp),
		.exValid(exValid),
		.exRes(exRes)
	);

	// stage 3 round and pack
	fpRound32 uRound (
		.clk(clk),
		.arstN(arstN),
		.exValid(exValid),
		.exRes(exRes),
		.outValid(outValid),
		.result(result)
	);

endmodule

`default_nettype wire

//--- fpMul32_tb.sv
// directed testbench for the pipelined fp32 multiplier with a bit exact reference model
`default_nettype none
`include "fpMul32_macros.svh"

module fpMul32_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fp32Pkg::*;

	localparam int MaxCycles = 5000;	// ~420 ops plus gaps, wide margin

	logic clk, arstN, inValid, outValid;
	roundMode rm;
	FP32 a, b, result;
	int cycle = 0;
	logic [31:0] lfsr;
	logic [31:0] expQ[$];	// expected words, issue order
	string nameQ[$];
	int dueQ[$];	// cycle in which each result must show up

	fpMul32 UUT (
		.clk(clk), .arstN(arstN), .inValid(inValid), .rm(rm),
		.a(a), .b(b), .outValid(outValid), .result(result)
	);

	always #2 clk = ~clk;	// 4 ns period

	// ------------------------------
	// reporting
	// ------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped on the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			failRun($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [31:0] refMul(logic [31:0] x, logic [31:0] y, roundMode mode);
		logic sp, xZero, yZero, xInf, yInf, xNan, yNan, g, r, st, up;
		logic [47:0] m;
		logic [23:0] kept;
		logic [30:0] mag;
		int e, k;
		xZero = x[30:23] == 8'd0;	// denormals count as zero
		yZero = y[30:23] == 8'd0;
		xInf = (x[30:23] == 8'hFF) && (x[22:0] == 23'd0);
		yInf = (y[30:23] == 8'hFF) && (y[22:0] == 23'd0);
		xNan = (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
		yNan = (y[30:23] == 8'hFF) && (y[22:0] != 23'd0);
		sp = x[31] ^ y[31];
		if (xNan || yNan || (xInf && yZero) || (yInf && xZero))
			return 32'h7FC00000;
		if (xInf || yInf)
			return {sp, 8'hFF, 23'd0};
		if (xZero || yZero)
			return {sp, 31'd0};
		m = 48'({1'b1, x[22:0]}) * 48'({1'b1, y[22:0]});	// exact product
		e = int'(x[30:23]) + int'(y[30:23]) - `FP_BIAS;
		if (m[47])
			e = e + 1;
		else
			m = m << 1;	// hidden bit to 47
		if (e >= `FP_EMAX)
			return {sp, 8'hFF, 23'd0};	// overflow is always infinity
		st = 1'b0;
		if (e < 1) begin
			k = 1 - e;	// shift into denormal form
			if (k >= 48) begin
				st = |m;
				m = '0;
			end
			else begin
				st = |(m & ((48'd1 << k) - 48'd1));
				m = m >> k;
			end
			e = 0;
		end
		kept = m[47:24];
		g = m[23];
		r = m[22];
		st = st | (|m[21:0]);
		case (mode)
			rmNearEven: up = g & (r | st | kept[0]);
			rmZero: up = 1'b0;
			rmPlusInf: up = (g | r | st) & ~sp;
			rmMinusInf: up = (g | r | st) & sp;
			default: up = g;	// ties away
		endcase
		mag = {e[7:0], kept[22:0]} + {30'd0, up};	// carry walks into the exponent
		return {sp, mag};
	endfunction

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// galois, taps 32 22 2 1
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);	// one step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic makeOperand(output logic [31:0] v);
		logic [31:0] s, e, f;
		takeBits(1, s);
		takeBits(7, e);
		takeBits(23, f);
		v = {s[0], 8'd48 + {1'b0, e[6:0]}, f[22:0]};	// exp 48..175, reaches the denormal range
	endtask

	task automatic sendOp(input string name, input logic [31:0] x, input logic [31:0] y,
		input roundMode m, input logic [31:0] expected);
		@(posedge clk);
		inValid <= 1'b1;
		a <= x;
		b <= y;
		rm <= m;
		expQ.push_back(expected);
		nameQ.push_back(name);
		dueQ.push_back(cycle + 1 + `FP_LATENCY);	// cycle has not counted this edge yet
	endtask

	task automatic issueOp(input string name, input logic [31:0] x, input logic [31:0] y,
		input roundMode m);
		sendOp(name, x, y, m, refMul(x, y, m));
	endtask

	task automatic idle();
		@(posedge clk);
		inValid <= 1'b0;
		repeat (2) @(posedge clk);	// small gap between tests
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic testExact();
		for (int i = 0; i < 5; i++) begin
			sendOp("exact 1.5*2", 32'h3FC00000, 32'h40000000, roundMode'(i[2:0]), 32'h40400000);
			sendOp("exact -3*0.25", 32'hC0400000, 32'h3E800000, roundMode'(i[2:0]), 32'hBF400000);
			sendOp("exact 1*pi", 32'h3F800000, 32'h40490FDB, roundMode'(i[2:0]), 32'h40490FDB);
		end
		idle();
	endtask

	// sticky only, guard tie with even lsb, tie with odd lsb, carry into exponent
	task automatic testRounding();
		logic [31:0] xs [4];
		logic [31:0] ys [4];
		xs = '{32'h3F800001, 32'h3F800800, 32'h3FC00000, 32'h3FB504F3};
		ys = '{32'h3F800001, 32'h3F800800, 32'h3F800001, 32'h3FB504F3};
		for (int p = 0; p < 4; p++)
			for (int s = 0; s < 2; s++)
				for (int i = 0; i < 5; i++)
					issueOp($sformatf("rounding pair %0d", p), xs[p] ^ {s[0], 31'd0}, ys[p],
						roundMode'(i[2:0]));
		idle();
	endtask

	task automatic testSpecials();
		sendOp("qnan*1", 32'h7FC00001, 32'h3F800000, rmNearEven, 32'h7FC00000);
		sendOp("1*snan", 32'h3F800000, 32'hFF800001, rmZero, 32'h7FC00000);
		sendOp("inf*0", 32'h7F800000, 32'h00000000, rmPlusInf, 32'h7FC00000);
		sendOp("-0*-inf", 32'h80000000, 32'hFF800000, rmMinusInf, 32'h7FC00000);
		sendOp("denormal*-inf", 32'h00400000, 32'hFF800000, rmNearMax, 32'h7FC00000);
		sendOp("inf*2", 32'h7F800000, 32'h40000000, rmNearEven, 32'h7F800000);
		sendOp("-inf*3", 32'hFF800000, 32'h40400000, rmZero, 32'hFF800000);
		sendOp("inf*-inf", 32'h7F800000, 32'hFF800000, rmPlusInf, 32'hFF800000);
		sendOp("0*5", 32'h00000000, 32'h40A00000, rmMinusInf, 32'h00000000);
		sendOp("-0*5", 32'h80000000, 32'h40A00000, rmNearMax, 32'h80000000);
		sendOp("denormal*2", 32'h00000001, 32'h40000000, rmPlusInf, 32'h00000000);
		sendOp("-denormal*3", 32'h807FFFFF, 32'h40400000, rmMinusInf, 32'h80000000);
		sendOp("-7*denormal", 32'hC0E00000, 32'h00000001, rmNearEven, 32'h80000000);
		idle();
	endtask

	// overflow, exact denormal, tie into smallest normal, deep underflow, sticky denormal
	task automatic testRange();
		logic [31:0] xs [5];
		logic [31:0] ys [5];
		xs = '{32'h7F000000, 32'h00800000, 32'h3F7FFFFF, 32'h0D000000, 32'h1F800001};
		ys = '{32'h40000000, 32'h3F000000, 32'h00800000, 32'h0D000000, 32'h20400003};
		for (int p = 0; p < 5; p++)
			for (int s = 0; s < 2; s++)
				for (int i = 0; i < 5; i++)
					issueOp($sformatf("range pair %0d", p), xs[p] ^ {s[0], 31'd0}, ys[p],
						roundMode'(i[2:0]));
		idle();
	endtask

	task automatic testStream();
		logic [31:0] x, y, bits;
		for (int i = 0; i < 300; i++) begin	// back to back, no gaps
			makeOperand(x);
			makeOperand(y);
			takeBits(3, bits);
			issueOp($sformatf("stream op %0d", i), x, y, roundMode'(bits[2:0] % 3'd5));
		end
		idle();
	endtask

	// ------------------------------
	// monitor and timeout
	// ------------------------------
	always @(negedge clk) begin : monitor
		string nm;
		if (!arstN && outValid)
			failRun("outValid was high while reset was asserted");
		else if (outValid) begin
			if (expQ.size() == 0)
				failRun("a result came out with no operation outstanding");
			else begin
				nm = nameQ.pop_front();
				checkValue(nm, expQ.pop_front(), result);
				checkValue({nm, " latency"}, 32'(dueQ.pop_front()), 32'(cycle));
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MaxCycles)
			failRun("timeout, the run went past its cycle limit");
	end

	initial begin
		lfsr = 32'd89561;
		clk = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		rm = rmNearEven;
		a = '0;
		b = '0;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		testExact();
		testRounding();
		testSpecials();
		testRange();
		testStream();
		repeat (`FP_LATENCY + 2) @(posedge clk);	// let the pipe drain
		if (expQ.size() != 0)
			failRun($sformatf("%0d results never came out of the pipeline", expQ.size()));
		else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
fp32Pkg.sv
fpMul32Decode.sv
fpMul32Execute.sv
fpRound32.sv
fpMul32.sv
fpMul32_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module fpMul32_tb --Mdir obj_dir -o simv

out=$(./obj_dir/simv 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
